// ==== bench/fsa_clkgen.sv ====
`default_nettype none

module fsa_clkgen #(
	parameter int PERIOD     = 20,
	parameter int RST_CYCLES = 8
) (
	output logic clk,
	output logic resetn
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// reset is released on a rising edge, like any other input.
	initial begin
		resetn = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		resetn <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== bench/fsa_tb.sv ====
`default_nettype none

module fsa_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int IMG_W      = 16;
	localparam int IMG_H      = 8;
	localparam int NUM_FRAMES = 10;
	localparam int DONE_WAIT  = IMG_W * IMG_H + 50;
	localparam logic [7:0] REF = 8'd128;

	typedef logic [fsa_geom_pkg::IMG_WW-1:0] xcoord_t;
	typedef logic [fsa_geom_pkg::IMG_HW-1:0] ycoord_t;

	logic clk;
	logic resetn;
	fsa_geom_pkg::pixel_t   i_pix;
	fsa_ctrl_pkg::rd_req_t  i_rd;
	logic                   i_r_sof;
	logic [7:0]             i_ref;
	xcoord_t                i_width;
	ycoord_t                i_height;
	fsa_geom_pkg::profile_t o_rd_data;
	logic                   o_done;
	logic                   o_lft_valid;
	xcoord_t                o_lft_edge;
	logic                   o_rt_valid;
	xcoord_t                o_rt_edge;

	// frame under test and the column profiles expected from it.
	logic [7:0] frame [IMG_H][IMG_W];
	fsa_geom_pkg::profile_t mdl_prof  [IMG_W];
	fsa_geom_pkg::profile_t held_prof [IMG_W];
	fsa_geom_pkg::profile_t chk_prof  [IMG_W];
	logic    exp_valid = 1'b0;
	xcoord_t exp_l = '0;
	xcoord_t exp_r = '0;

	logic last_pix = 1'b0;
	logic last_d1 = 1'b0;
	logic last_d2 = 1'b0;
	logic last_d3 = 1'b0;
	logic done_seen = 1'b0;
	logic rd_chk = 1'b0;
	logic chk_d1 = 1'b0;
	logic chk_d2 = 1'b0;
	fsa_geom_pkg::profile_t rd_exp = '0;
	fsa_geom_pkg::profile_t exp_d1 = '0;
	fsa_geom_pkg::profile_t exp_d2 = '0;
	xcoord_t rd_addr = '0;
	xcoord_t addr_d1 = '0;
	xcoord_t addr_d2 = '0;

	int seed = 21;
	string test_name = "reset_idle";
	int done_err = 0;
	int idle_err = 0;
	int edge_err = 0;
	int rd_err = 0;
	int to_err = 0;
	int errs_at_start;
	int tests_run = 0;
	int tests_failed = 0;

	fsa_clkgen #(
		.PERIOD     (20),
		.RST_CYCLES (8)
	) fsa_clkgen_inst (
		.clk    (clk),
		.resetn (resetn)
	);

	fsa_top #(
		.BR_NUM(4)
	) fsa_top_inst (
		.clk         (clk),
		.resetn      (resetn),
		.i_pix       (i_pix),
		.i_ref       (i_ref),
		.i_width     (i_width),
		.i_height    (i_height),
		.i_r_sof     (i_r_sof),
		.i_rd        (i_rd),
		.o_rd_data   (o_rd_data),
		.o_done      (o_done),
		.o_lft_valid (o_lft_valid),
		.o_lft_edge  (o_lft_edge),
		.o_rt_valid  (o_rt_valid),
		.o_rt_edge   (o_rt_edge)
	);

	// expected responses delayed to the cycle in which the DUT answers.
	always @(posedge clk) begin
		last_d1 <= last_pix;
		last_d2 <= last_d1;
		last_d3 <= last_d2;
		chk_d1  <= rd_chk;
		chk_d2  <= chk_d1;
		exp_d1  <= rd_exp;
		exp_d2  <= exp_d1;
		addr_d1 <= rd_addr;
		addr_d2 <= addr_d1;
		if (o_done) begin
			done_seen <= 1'b1;
		end
	end

	// ####################################################################
	// checks
	// ####################################################################

	assert property (@(posedge clk) disable iff (!resetn) o_done == last_d3)
	else begin
		done_err++;
		$display("[ERROR] %s o_done three cycles after last pixel: expected %0b, actual %0b",
			test_name, last_d3, o_done);
	end

	assert property (@(posedge clk) disable iff (!resetn)
		(!done_seen && !o_done) |-> (!o_lft_valid && !o_rt_valid))
	else begin
		idle_err++;
		$display("[ERROR] %s valid bits before first frame: expected 0/0, actual %0b/%0b",
			test_name, o_lft_valid, o_rt_valid);
	end

	assert property (@(posedge clk) disable iff (!resetn)
		o_done |-> (o_lft_valid == exp_valid && o_rt_valid == exp_valid &&
			(!exp_valid || (o_lft_edge == exp_l && o_rt_edge == exp_r))))
	else begin
		edge_err++;
		$display("[ERROR] %s edges: expected v=%0b l=%0d r=%0d, actual v=%0b/%0b l=%0d r=%0d",
			test_name, exp_valid, exp_l, exp_r,
			o_lft_valid, o_rt_valid, o_lft_edge, o_rt_edge);
	end

	// top and bottom only mean something for a valid profile.
	assert property (@(posedge clk) disable iff (!resetn)
		chk_d2 |-> (o_rd_data.valid == exp_d2.valid &&
			(!exp_d2.valid || (o_rd_data.top == exp_d2.top && o_rd_data.bot == exp_d2.bot))))
	else begin
		rd_err++;
		$display("[ERROR] %s col %0d: expected v=%0b t=%0d b=%0d, actual v=%0b t=%0d b=%0d",
			test_name, addr_d2, exp_d2.valid, exp_d2.top, exp_d2.bot,
			o_rd_data.valid, o_rd_data.top, o_rd_data.bot);
	end

	// ####################################################################
	// model and stimulus
	// ####################################################################

	function automatic int error_total();
		return done_err + idle_err + edge_err + rd_err + to_err;
	endfunction

	// first and last dark row per column, then the outermost dark columns.
	function automatic void compute_model();
		exp_valid = 1'b0;
		exp_l = '0;
		exp_r = '0;
		for (int x = 0; x < IMG_W; x++) begin
			mdl_prof[x] = '0;
			for (int y = 0; y < IMG_H; y++) begin
				if (frame[y][x] < REF) begin
					if (!mdl_prof[x].valid) begin
						mdl_prof[x].valid = 1'b1;
						mdl_prof[x].top = ycoord_t'(y);
					end
					mdl_prof[x].bot = ycoord_t'(y);
				end
			end
			if (mdl_prof[x].valid) begin
				if (!exp_valid) begin
					exp_l = xcoord_t'(x);
				end
				exp_r = xcoord_t'(x);
				exp_valid = 1'b1;
			end
		end
	endfunction

	function automatic void fill_rect();
		for (int y = 0; y < IMG_H; y++) begin
			for (int x = 0; x < IMG_W; x++) begin
				if (x >= 3 && x <= 11 && y >= 2 && y <= 5) begin
					frame[y][x] = 8'h20;
				end else begin
					frame[y][x] = 8'hd0;
				end
			end
		end
	endfunction

	function automatic void fill_bright();
		for (int y = 0; y < IMG_H; y++) begin
			for (int x = 0; x < IMG_W; x++) begin
				frame[y][x] = 8'hff;
			end
		end
	endfunction

	// about one pixel in sixteen is dark, so the edges move between frames.
	function automatic void fill_random();
		logic [31:0] r;
		for (int y = 0; y < IMG_H; y++) begin
			for (int x = 0; x < IMG_W; x++) begin
				r = $random(seed);
				if (r[3:0] == 4'h0) begin
					frame[y][x] = {1'b0, r[10:4]};
				end else begin
					frame[y][x] = {1'b1, r[10:4]};
				end
			end
		end
	endfunction

	task automatic send_frame();
		fsa_geom_pkg::pixel_t pix;
		for (int y = 0; y < IMG_H; y++) begin
			for (int x = 0; x < IMG_W; x++) begin
				@(posedge clk);
				pix.valid = 1'b1;
				pix.sof   = (x == 0 && y == 0);
				pix.eol   = (x == IMG_W - 1);
				pix.data  = frame[y][x];
				i_pix    <= pix;
				last_pix <= (x == IMG_W - 1 && y == IMG_H - 1);
			end
		end
		@(posedge clk);
		i_pix    <= '0;
		last_pix <= 1'b0;
	endtask

	task automatic wait_done();
		logic seen;
		seen = 1'b0;
		for (int n = 0; n < DONE_WAIT && !seen; n++) begin
			@(negedge clk);
			seen = o_done;
		end
		if (!seen) begin
			to_err++;
			$display("%s: o_done never came after the last pixel of the frame", test_name);
		end
		repeat (2) @(negedge clk);
	endtask

	task automatic run_frame();
		compute_model();
		send_frame();
		wait_done();
	endtask

	// reads every column of the reader bank and checks it against chk_prof.
	task automatic read_columns(input logic do_rsof);
		fsa_ctrl_pkg::rd_req_t req;
		if (do_rsof) begin
			@(posedge clk);
			i_r_sof <= 1'b1;
		end
		for (int x = 0; x < IMG_W; x++) begin
			@(posedge clk);
			i_r_sof <= 1'b0;
			req.en   = 1'b1;
			req.addr = xcoord_t'(x);
			i_rd    <= req;
			rd_chk  <= 1'b1;
			rd_exp  <= chk_prof[x];
			rd_addr <= xcoord_t'(x);
		end
		@(posedge clk);
		i_rd   <= '0;
		rd_chk <= 1'b0;
		repeat (3) @(negedge clk);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errs_at_start = error_total();
	endtask

	task automatic finish_test();
		int n;
		n = error_total() - errs_at_start;
		tests_run++;
		if (n != 0) begin
			tests_failed++;
		end
		$display("test %-12s %s, %0d errors", test_name, (n == 0) ? "ok" : "bad", n);
	endtask

	// ####################################################################
	// test sequence
	// ####################################################################

	initial begin : watchdog
		repeat (NUM_FRAMES * (IMG_W * IMG_H + 200)) @(posedge clk);
		$display("watchdog: the run took longer than its cycle budget");
		$display("TB FAILED");
		$finish;
	end

	initial begin
		i_pix    = '0;
		i_rd     = '0;
		i_r_sof  = 1'b0;
		i_ref    = REF;
		i_width  = xcoord_t'(IMG_W);
		i_height = ycoord_t'(IMG_H);

		wait (resetn);
		start_test("reset_idle");
		repeat (16) @(negedge clk);
		finish_test();

		start_test("rect_edges");
		fill_rect();
		run_frame();
		finish_test();

		start_test("readback");
		chk_prof = mdl_prof;
		read_columns(1'b1);
		finish_test();

		start_test("random");
		for (int i = 0; i < 5; i++) begin
			fill_random();
			run_frame();
		end
		finish_test();

		// the held frame must survive two later frames.
		start_test("held_frame");
		fill_random();
		run_frame();
		held_prof = mdl_prof;
		chk_prof = held_prof;
		read_columns(1'b1);
		for (int i = 0; i < 2; i++) begin
			fill_random();
			run_frame();
		end
		chk_prof = held_prof;
		read_columns(1'b0);
		finish_test();

		start_test("bright");
		fill_bright();
		run_frame();
		chk_prof = mdl_prof;
		read_columns(1'b1);
		finish_test();

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_total());
		if (error_total() == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
src/fsa_geom_pkg.sv
src/fsa_ctrl_pkg.sv
src/fsa_profile_ram.sv
src/fsa_bank_rotator.sv
src/fsa_profile_core.sv
src/fsa_edge_scan.sv
src/fsa_top.sv
bench/fsa_clkgen.sv
bench/fsa_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator, then scan the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module fsa_tb -o fsa_sim
./obj_dir/fsa_sim | tee sim.log

if grep -q "TB FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
exit 0

// ==== src/fsa_bank_rotator.sv ====
`default_nettype none

module fsa_bank_rotator #(
	parameter int BR_NUM = 4
) (
	input  wire                     clk,
	input  wire                     resetn,
	input  wire                     i_wr_sof,
	input  wire                     i_wr_done,
	output fsa_ctrl_pkg::bank_bmp_t o_w_bmp,
	input  wire                     i_r_sof,
	output fsa_ctrl_pkg::bank_bmp_t o_r_bmp
);

	localparam fsa_ctrl_pkg::bank_bmp_t BANK_MASK =
		fsa_ctrl_pkg::bank_bmp_t'((1 << BR_NUM) - 1);

	// keeps the lowest set bit only.
	function automatic fsa_ctrl_pkg::bank_bmp_t lowest_bit(
		input fsa_ctrl_pkg::bank_bmp_t v
	);
		return v & (~v + 1'b1);
	endfunction

	// latest complete bank.
	fsa_ctrl_pkg::bank_bmp_t c_bmp;
	// write bank one cycle back, which is the bank of a frame that ends
	// just as the next one starts.
	fsa_ctrl_pkg::bank_bmp_t w_bmp_d1;
	fsa_ctrl_pkg::bank_bmp_t free_all;
	fsa_ctrl_pkg::bank_bmp_t free_nw;
	fsa_ctrl_pkg::bank_bmp_t pick;

	always_comb begin
		free_all = ~(o_r_bmp | c_bmp) & BANK_MASK;
		free_nw  = free_all & ~o_w_bmp;
		// the running write bank is avoided too, so a frame still draining
		// its last writes is not handed out again.
		if (free_nw != '0) begin
			pick = lowest_bit(free_nw);
		end else begin
			pick = lowest_bit(free_all);
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_w_bmp  <= '0;
			o_r_bmp  <= '0;
			c_bmp    <= '0;
			w_bmp_d1 <= '0;
		end else begin
			w_bmp_d1 <= o_w_bmp;
			if (i_wr_sof) begin
				o_w_bmp <= pick;
			end
			if (i_wr_done) begin
				c_bmp <= w_bmp_d1;
			end
			if (i_r_sof) begin
				o_r_bmp <= c_bmp;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/fsa_ctrl_pkg.sv ====
`default_nettype none

package fsa_ctrl_pkg;

	localparam int BMP_MAX = 8;

	// one-hot bank select, only the low BR_NUM bits are ever set.
	typedef logic [BMP_MAX-1:0] bank_bmp_t;

	typedef enum logic {
		IDLE,
		ACTIVE
	} core_state_e;

	// read request issued by the core and by the host.
	typedef struct packed {
		logic                            en;
		logic [fsa_geom_pkg::IMG_WW-1:0] addr;
	} rd_req_t;

endpackage

`default_nettype wire

// ==== src/fsa_edge_scan.sv ====
`default_nettype none

module fsa_edge_scan (
	input  wire                              clk,
	input  wire                              resetn,
	input  wire fsa_geom_pkg::col_result_t   i_col,
	output logic                             o_done,
	output logic                             o_lft_valid,
	output logic [fsa_geom_pkg::IMG_WW-1:0]  o_lft_edge,
	output logic                             o_rt_valid,
	output logic [fsa_geom_pkg::IMG_WW-1:0]  o_rt_edge
);

	logic found;
	logic [fsa_geom_pkg::IMG_WW-1:0] min_x;
	logic [fsa_geom_pkg::IMG_WW-1:0] max_x;
	logic base_found;
	logic hit;
	logic nxt_found;
	logic [fsa_geom_pkg::IMG_WW-1:0] nxt_min;
	logic [fsa_geom_pkg::IMG_WW-1:0] nxt_max;
	logic publish;

	// column 0 of the last row starts a fresh scan.
	always_comb begin
		base_found = (i_col.x == '0) ? 1'b0 : found;
		hit        = i_col.prof.valid;
		nxt_found  = base_found || hit;
		if (hit && (!base_found || i_col.x < min_x)) begin
			nxt_min = i_col.x;
		end else begin
			nxt_min = min_x;
		end
		if (hit && (!base_found || i_col.x > max_x)) begin
			nxt_max = i_col.x;
		end else begin
			nxt_max = max_x;
		end
	end

	assign publish = i_col.strobe && i_col.last;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			found       <= 1'b0;
			o_done      <= 1'b0;
			o_lft_valid <= 1'b0;
			o_rt_valid  <= 1'b0;
		end else begin
			o_done <= publish;
			if (i_col.strobe) begin
				found <= nxt_found;
			end
			if (publish) begin
				o_lft_valid <= nxt_found;
				o_rt_valid  <= nxt_found;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_col.strobe) begin
			min_x <= nxt_min;
			max_x <= nxt_max;
		end
		if (publish) begin
			o_lft_edge <= nxt_min;
			o_rt_edge  <= nxt_max;
		end
	end

endmodule

`default_nettype wire

// ==== src/fsa_geom_pkg.sv ====
`default_nettype none

package fsa_geom_pkg;

	localparam int IMG_WW = 12;
	localparam int IMG_HW = 12;
	localparam int PIX_W  = 8;

	// one pixel of the input stream.
	typedef struct packed {
		logic             valid;
		logic             sof;
		logic             eol;
		logic [PIX_W-1:0] data;
	} pixel_t;

	// bank word: first and last dark row of one column.
	typedef struct packed {
		logic              valid;
		logic [IMG_HW-1:0] top;
		logic [IMG_HW-1:0] bot;
	} profile_t;

	typedef struct packed {
		logic              strobe;
		logic              last;
		logic [IMG_WW-1:0] x;
		profile_t          prof;
	} col_result_t;

endpackage

`default_nettype wire

// ==== src/fsa_profile_core.sv ====
`default_nettype none

module fsa_profile_core (
	input  wire                              clk,
	input  wire                              resetn,
	input  wire fsa_geom_pkg::pixel_t        i_pix,
	input  wire [fsa_geom_pkg::PIX_W-1:0]    i_ref,
	input  wire [fsa_geom_pkg::IMG_WW-1:0]   i_width,
	input  wire [fsa_geom_pkg::IMG_HW-1:0]   i_height,
	output logic                             o_wr_sof,
	output fsa_ctrl_pkg::rd_req_t            o_rd,
	input  wire fsa_geom_pkg::profile_t      i_rd_data,
	output logic                             o_wr_en,
	output logic [fsa_geom_pkg::IMG_WW-1:0]  o_wr_addr,
	output fsa_geom_pkg::profile_t           o_wr_data,
	output logic                             o_wr_done,
	output fsa_geom_pkg::col_result_t        o_col
);

	typedef struct packed {
		logic                            valid;
		logic                            first_row;
		logic                            last_row;
		logic                            last_col;
		logic                            dark;
		logic [fsa_geom_pkg::IMG_WW-1:0] x;
		logic [fsa_geom_pkg::IMG_HW-1:0] y;
	} stage_t;

	fsa_ctrl_pkg::core_state_e state;
	logic [fsa_geom_pkg::IMG_WW-1:0] x_cnt;
	logic [fsa_geom_pkg::IMG_HW-1:0] y_cnt;
	logic [fsa_geom_pkg::IMG_WW-1:0] cur_x;
	logic [fsa_geom_pkg::IMG_HW-1:0] cur_y;
	logic accept;
	stage_t s_in;
	stage_t s1;
	stage_t s2;
	fsa_geom_pkg::profile_t stored;
	fsa_geom_pkg::profile_t merged;

	// ###################################################################
	// pixel position
	// ###################################################################

	assign accept = i_pix.valid && (i_pix.sof || state == fsa_ctrl_pkg::ACTIVE);
	assign cur_x  = i_pix.sof ? '0 : x_cnt;
	assign cur_y  = i_pix.sof ? '0 : y_cnt;
	assign o_wr_sof = i_pix.valid && i_pix.sof;

	always_comb begin
		s_in.valid     = accept;
		s_in.first_row = (cur_y == '0);
		s_in.last_row  = (cur_y == i_height - 1'b1);
		s_in.last_col  = (cur_x == i_width - 1'b1);
		s_in.dark      = (i_pix.data < i_ref);
		s_in.x         = cur_x;
		s_in.y         = cur_y;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= fsa_ctrl_pkg::IDLE;
			x_cnt <= '0;
			y_cnt <= '0;
		end else if (accept) begin
			if (i_pix.eol) begin
				x_cnt <= '0;
				y_cnt <= cur_y + 1'b1;
			end else begin
				x_cnt <= cur_x + 1'b1;
				y_cnt <= cur_y;
			end
			if (i_pix.eol && s_in.last_row) begin
				state <= fsa_ctrl_pkg::IDLE;
			end else begin
				state <= fsa_ctrl_pkg::ACTIVE;
			end
		end
	end

	// row 0 never looks at stored data, so its read is not issued.
	always_comb begin
		o_rd.en   = accept && !s_in.first_row;
		o_rd.addr = cur_x;
	end

	// ###################################################################
	// read-modify-write pipeline
	// ###################################################################

	always_ff @(posedge clk) begin
		if (!resetn) begin
			s1 <= '0;
			s2 <= '0;
		end else begin
			s1 <= s_in;
			s2 <= s1;
		end
	end

	always_comb begin
		stored = s2.first_row ? '0 : i_rd_data;
		merged = stored;
		if (s2.dark) begin
			if (!stored.valid) begin
				merged.valid = 1'b1;
				merged.top   = s2.y;
			end
			merged.bot = s2.y;
		end
	end

	assign o_wr_en   = s2.valid;
	assign o_wr_addr = s2.x;
	assign o_wr_data = merged;
	assign o_wr_done = s2.valid && s2.last_row && s2.last_col;

	always_comb begin
		o_col.strobe = s2.valid && s2.last_row;
		o_col.last   = s2.last_col;
		o_col.x      = s2.x;
		o_col.prof   = merged;
	end

endmodule

`default_nettype wire

// ==== src/fsa_profile_ram.sv ====
`default_nettype none

module fsa_profile_ram (
	input  wire                              clk,
	input  wire                              i_wr_en,
	input  wire [fsa_geom_pkg::IMG_WW-1:0]   i_wr_addr,
	input  wire fsa_geom_pkg::profile_t      i_wr_data,
	input  wire                              i_rd_en,
	input  wire [fsa_geom_pkg::IMG_WW-1:0]   i_rd_addr,
	output fsa_geom_pkg::profile_t           o_rd_data
);

	localparam int DEPTH = 2 ** fsa_geom_pkg::IMG_WW;

	fsa_geom_pkg::profile_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// read data holds its last value while no read is enabled.
	always_ff @(posedge clk) begin
		if (i_rd_en) begin
			o_rd_data <= mem[i_rd_addr];
		end
	end

endmodule

`default_nettype wire

// ==== src/fsa_top.sv ====
`default_nettype none

module fsa_top #(
	parameter int BR_NUM = 4
) (
	input  wire                              clk,
	input  wire                              resetn,
	input  wire fsa_geom_pkg::pixel_t        i_pix,
	input  wire [fsa_geom_pkg::PIX_W-1:0]    i_ref,
	input  wire [fsa_geom_pkg::IMG_WW-1:0]   i_width,
	input  wire [fsa_geom_pkg::IMG_HW-1:0]   i_height,
	input  wire                              i_r_sof,
	input  wire fsa_ctrl_pkg::rd_req_t       i_rd,
	output fsa_geom_pkg::profile_t           o_rd_data,
	output logic                             o_done,
	output logic                             o_lft_valid,
	output logic [fsa_geom_pkg::IMG_WW-1:0]  o_lft_edge,
	output logic                             o_rt_valid,
	output logic [fsa_geom_pkg::IMG_WW-1:0]  o_rt_edge
);

	// read clients: the host and the core.
	localparam int NCLI     = 2;
	localparam int CLI_HOST = 0;
	localparam int CLI_CORE = 1;

	logic core_wr_sof;
	logic core_wr_en;
	logic core_wr_done;
	logic [fsa_geom_pkg::IMG_WW-1:0] core_wr_addr;
	fsa_geom_pkg::profile_t core_wr_data;
	fsa_geom_pkg::col_result_t core_col;
	fsa_ctrl_pkg::rd_req_t core_rd;
	fsa_ctrl_pkg::bank_bmp_t w_bmp;
	fsa_ctrl_pkg::bank_bmp_t r_bmp;
	fsa_ctrl_pkg::bank_bmp_t wr_bmp_q;

	fsa_ctrl_pkg::rd_req_t   cli_req   [NCLI];
	fsa_ctrl_pkg::bank_bmp_t cli_bmp   [NCLI];
	fsa_ctrl_pkg::bank_bmp_t cli_bmp_q [NCLI];
	fsa_geom_pkg::profile_t  cli_mux   [NCLI];
	fsa_geom_pkg::profile_t  cli_data_q[NCLI];

	logic                            bank_rd_en  [BR_NUM];
	logic [fsa_geom_pkg::IMG_WW-1:0] bank_rd_addr[BR_NUM];
	fsa_geom_pkg::profile_t          bank_rd_data[BR_NUM];

	assign cli_req[CLI_HOST] = i_rd;
	assign cli_bmp[CLI_HOST] = r_bmp;
	assign cli_req[CLI_CORE] = core_rd;
	assign cli_bmp[CLI_CORE] = w_bmp;
	assign o_rd_data = cli_data_q[CLI_HOST];

	// ###################################################################
	// bank read routing
	// ###################################################################

	always_comb begin
		for (int b = 0; b < BR_NUM; b++) begin
			bank_rd_en[b]   = 1'b0;
			bank_rd_addr[b] = '0;
			for (int c = 0; c < NCLI; c++) begin
				if (cli_req[c].en && cli_bmp[c][b]) begin
					bank_rd_en[b]   = 1'b1;
					bank_rd_addr[b] = cli_req[c].addr;
				end
			end
		end
	end

	// the bank select travels with the request, so the data mux follows
	// the bank that was actually read.
	always_comb begin
		for (int c = 0; c < NCLI; c++) begin
			cli_mux[c] = '0;
			for (int b = 0; b < BR_NUM; b++) begin
				if (cli_bmp_q[c][b]) begin
					cli_mux[c] = fsa_geom_pkg::profile_t'(cli_mux[c] | bank_rd_data[b]);
				end
			end
		end
	end

	// writes land two cycles after acceptance, so they use the write bank
	// as it stood one cycle after the pixel.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_bmp_q <= '0;
			for (int c = 0; c < NCLI; c++) begin
				cli_bmp_q[c] <= '0;
			end
		end else begin
			wr_bmp_q <= w_bmp;
			for (int c = 0; c < NCLI; c++) begin
				cli_bmp_q[c] <= cli_bmp[c];
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int c = 0; c < NCLI; c++) begin
			cli_data_q[c] <= cli_mux[c];
		end
	end

	for (genvar b = 0; b < BR_NUM; b++) begin : g_bank
		fsa_profile_ram fsa_profile_ram_inst (
			.clk       (clk),
			.i_wr_en   (core_wr_en && wr_bmp_q[b]),
			.i_wr_addr (core_wr_addr),
			.i_wr_data (core_wr_data),
			.i_rd_en   (bank_rd_en[b]),
			.i_rd_addr (bank_rd_addr[b]),
			.o_rd_data (bank_rd_data[b])
		);
	end

	fsa_bank_rotator #(
		.BR_NUM(BR_NUM)
	) fsa_bank_rotator_inst (
		.clk       (clk),
		.resetn    (resetn),
		.i_wr_sof  (core_wr_sof),
		.i_wr_done (core_wr_done),
		.o_w_bmp   (w_bmp),
		.i_r_sof   (i_r_sof),
		.o_r_bmp   (r_bmp)
	);

	fsa_profile_core fsa_profile_core_inst (
		.clk       (clk),
		.resetn    (resetn),
		.i_pix     (i_pix),
		.i_ref     (i_ref),
		.i_width   (i_width),
		.i_height  (i_height),
		.o_wr_sof  (core_wr_sof),
		.o_rd      (core_rd),
		.i_rd_data (cli_data_q[CLI_CORE]),
		.o_wr_en   (core_wr_en),
		.o_wr_addr (core_wr_addr),
		.o_wr_data (core_wr_data),
		.o_wr_done (core_wr_done),
		.o_col     (core_col)
	);

	fsa_edge_scan fsa_edge_scan_inst (
		.clk         (clk),
		.resetn      (resetn),
		.i_col       (core_col),
		.o_done      (o_done),
		.o_lft_valid (o_lft_valid),
		.o_lft_edge  (o_lft_edge),
		.o_rt_valid  (o_rt_valid),
		.o_rt_edge   (o_rt_edge)
	);

endmodule

`default_nettype wire
